/* rtl/bypassPkg.sv */
/*
 * Shared types for the register-specifier bypass logic
 * Specifier width, in-flight destination entry, destination decode,
 * bypass source positions and the one-hot select type
 */
`default_nettype none

package bypassPkg;

  // ----------------------------------------------------------
  // Register specifiers
  // ----------------------------------------------------------

  // 32 architectural registers
  localparam int SPEC_W = 5;

  typedef logic [SPEC_W-1:0] specT;

  // Written by the A-side link (r31) decode
  localparam specT LINK_REG = specT'(31);

  // ----------------------------------------------------------
  // In-flight destination
  // ----------------------------------------------------------

  // One EX, MEM or WB entry, 7 bits
  typedef struct packed {
    specT spec;
    logic valid;   // Will write the register file
    logic isLoad;  // Result comes from memory (B side only)
  } destT;

  // Destination field chosen by the decoder at issue
  typedef enum logic [1:0] {
    destNone = 2'd0,
    destRd   = 2'd1,
    destRt   = 2'd2,
    destR31  = 2'd3
  } destSelE;

  // ----------------------------------------------------------
  // Bypass mux select
  // ----------------------------------------------------------

  // Bit position of each source inside a one-hot select
  typedef enum logic [2:0] {
    srcNone = 3'd0,
    srcAMem = 3'd1,
    srcBMem = 3'd2,
    srcAEx  = 3'd3,
    srcBEx  = 3'd4
  } bypassSrcE;

  // One-hot, indexed by bypassSrcE
  typedef logic [srcBEx:srcNone] bypassSelT;

endpackage

`default_nettype wire

/* rtl/destIf.sv */
/*
 * Bundle of the four in-flight destinations (A/B, EX/MEM)
 * Read by the specifier comparators and by the control block
 */
`timescale 1ns/10ps
`default_nettype none

interface destIf import bypassPkg::*; ();

  // Driven by the A and B destination chains
  destT aEx;
  destT aMem;
  destT bEx;
  destT bMem;

  // Source specifier comparators
  modport cmp (
    input aEx, aMem, bEx, bMem
  );

  // Enables, writeback stage and load tracking
  modport ctrl (
    input aEx, aMem, bEx, bMem
  );

endinterface

`default_nettype wire

/* rtl/destChain.sv */
/*
 * Per-side destination decode and EX/MEM destination chain
 * Entry is invalidated for kill, no destination, r0 and exceptions
 */
`timescale 1ns/10ps
`default_nettype none

module destChain import bypassPkg::*; #(
  parameter bit hasLink = 1'b0
) (
  input  logic    phi1,
  input  logic    rstN,
  input  logic    stall,
  input  logic    except,
  input  destSelE destSel,
  input  specT    rtSpec,
  input  specT    rdSpec,
  input  logic    kill,
  input  logic    isLoad,
  output destT    exDest,
  output destT    memDest
);

  specT decSpec;
  logic hasDest;
  destT issueDest;

  // ----------------------------------------------------------
  // Destination decode
  // ----------------------------------------------------------
  always_comb begin
    decSpec = '0;
    hasDest = 1'b0;
    case (destSel)
      destRd: begin
        decSpec = rdSpec;
        hasDest = 1'b1;
      end
      destRt: begin
        decSpec = rtSpec;
        hasDest = 1'b1;
      end
      destR31: begin
        // No link register on the B side, same as no destination
        if (hasLink) begin
          decSpec = LINK_REG;
          hasDest = 1'b1;
        end
      end
      default: begin
        hasDest = 1'b0;
      end
    endcase
  end

  // r0 is never written, so it must never be bypassed
  assign issueDest.spec   = decSpec;
  assign issueDest.isLoad = isLoad;
  assign issueDest.valid  = hasDest & ~kill & (decSpec != '0) & ~except;

  // ----------------------------------------------------------
  // EX and MEM stages
  // ----------------------------------------------------------
  always_ff @(posedge phi1 or negedge rstN) begin
    if (!rstN) begin
      exDest  <= '0;
      memDest <= '0;
    end else if (!stall) begin
      exDest        <= issueDest;
      memDest       <= exDest;
      memDest.valid <= exDest.valid & ~except;
    end else if (except) begin
      // Exception flushes even while stalled
      exDest.valid  <= 1'b0;
      memDest.valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* rtl/specCompare.sv */
/*
 * One source specifier against the four in-flight destinations
 * Priority encode to a one-hot bypass select, registered
 */
`timescale 1ns/10ps
`default_nettype none

module specCompare import bypassPkg::*; (
  input  logic      phi1,
  input  logic      rstN,
  input  logic      stall,
  input  specT      srcSpec,
  destIf.cmp        dest,
  output bypassSelT bypassSel
);

  logic      aExHit;
  logic      bExHit;
  logic      aMemHit;
  logic      bMemHit;
  bypassSelT selNext;

  // Only valid entries may forward
  function automatic logic specHit(destT entry, specT src);
    return entry.valid && (entry.spec == src);
  endfunction

  assign aExHit  = specHit(dest.aEx, srcSpec);
  assign bExHit  = specHit(dest.bEx, srcSpec);
  assign aMemHit = specHit(dest.aMem, srcSpec);
  assign bMemHit = specHit(dest.bMem, srcSpec);

  // ----------------------------------------------------------
  // Priority select
  // ----------------------------------------------------------
  // Youngest wins: EX over MEM, B over A within a stage
  always_comb begin
    selNext = '0;
    if (bExHit) begin
      selNext[srcBEx] = 1'b1;
    end else if (aExHit) begin
      selNext[srcAEx] = 1'b1;
    end else if (bMemHit) begin
      selNext[srcBMem] = 1'b1;
    end else if (aMemHit) begin
      selNext[srcAMem] = 1'b1;
    end else begin
      selNext[srcNone] = 1'b1;
    end
  end

  // Select used by the datapath mux in the following cycle
  always_ff @(posedge phi1 or negedge rstN) begin
    if (!rstN) begin
      bypassSel          <= '0;
      bypassSel[srcNone] <= 1'b1;
    end else if (!stall) begin
      bypassSel <= selNext;
    end
  end

endmodule

`default_nettype wire

/* rtl/bypassCtrl.sv */
/*
 * Bypass control: B-side writeback stage and delayed stall
 * Datapath stage enables, load-bypass flags and load-data write enable
 */
`timescale 1ns/10ps
`default_nettype none

module bypassCtrl import bypassPkg::*; (
  input  logic      phi1,
  input  logic      rstN,
  input  logic      stall,
  input  logic      except,
  destIf.ctrl       dest,
  input  bypassSelT sBypassSel,
  input  bypassSelT tBypassSel,
  output logic      aExEn,
  output logic      aMemEn,
  output logic      bExEn,
  output logic      bMemEn,
  output logic      bWasLoad,
  output logic      sBypassLoad,
  output logic      tBypassLoad,
  output logic      loadWriteEn
);

  destT wbDest;
  logic stallDly;

  // ----------------------------------------------------------
  // B writeback stage and stall delay
  // ----------------------------------------------------------
  always_ff @(posedge phi1 or negedge rstN) begin
    if (!rstN) begin
      wbDest   <= '0;
      stallDly <= 1'b0;
    end else begin
      stallDly <= stall;
      if (!stall) begin
        wbDest       <= dest.bMem;
        wbDest.valid <= dest.bMem.valid & ~except;
      end else if (except) begin
        wbDest.valid <= 1'b0;
      end
    end
  end

  // ----------------------------------------------------------
  // Datapath stage enables
  // ----------------------------------------------------------
  // Killed or empty stages leave the datapath registers alone
  assign aExEn  = dest.aEx.valid & ~stall;
  assign aMemEn = dest.aMem.valid & ~stall;
  assign bExEn  = dest.bEx.valid & ~stall;
  assign bMemEn = dest.bMem.valid & ~stall;

  // ----------------------------------------------------------
  // Load tracking
  // ----------------------------------------------------------
  assign bWasLoad = wbDest.valid & wbDest.isLoad;

  // Load data arrives late, so a B MEM bypass of a load takes the load path
  assign sBypassLoad = sBypassSel[srcBMem] & bWasLoad;
  assign tBypassLoad = tBypassSel[srcBMem] & bWasLoad;

  // Capture load data only if the previous cycle moved the pipe
  assign loadWriteEn = dest.bMem.valid & dest.bMem.isLoad & ~stallDly;

endmodule

`default_nettype wire

/* rtl/bypassSpec.sv */
/*
 * Register-specifier bypass logic, top level
 * A/B destination chains, S/T specifier comparators and bypass control
 */
`timescale 1ns/10ps
`default_nettype none

module bypassSpec import bypassPkg::*; (
  input  logic      phi1,
  input  logic      rstN,
  input  logic      stall,
  input  logic      except,
  // A-side issue
  input  destSelE   aDestSel,
  input  specT      aRtSpec,
  input  specT      aRdSpec,
  input  logic      aKill,
  // B-side issue
  input  destSelE   bDestSel,
  input  specT      bRtSpec,
  input  specT      bRdSpec,
  input  logic      bKill,
  input  logic      bIsLoad,
  // Source specifiers
  input  specT      sSrcSpec,
  input  specT      tSrcSpec,
  // Bypass mux control
  output bypassSelT sBypassSel,
  output bypassSelT tBypassSel,
  output logic      sBypassLoad,
  output logic      tBypassLoad,
  output logic      bWasLoad,
  // Datapath enables
  output logic      aExEn,
  output logic      aMemEn,
  output logic      bExEn,
  output logic      bMemEn,
  output logic      loadWriteEn
);

  // In-flight destinations
  destIf destBus ();

  // ----------------------------------------------------------
  // Destination chains
  // ----------------------------------------------------------
  // A side has the link register and never loads
  destChain #(
    .hasLink (1'b1)
  ) aChain (
    .phi1    (phi1),
    .rstN    (rstN),
    .stall   (stall),
    .except  (except),
    .destSel (aDestSel),
    .rtSpec  (aRtSpec),
    .rdSpec  (aRdSpec),
    .kill    (aKill),
    .isLoad  (1'b0),
    .exDest  (destBus.aEx),
    .memDest (destBus.aMem)
  );

  destChain #(
    .hasLink (1'b0)
  ) bChain (
    .phi1    (phi1),
    .rstN    (rstN),
    .stall   (stall),
    .except  (except),
    .destSel (bDestSel),
    .rtSpec  (bRtSpec),
    .rdSpec  (bRdSpec),
    .kill    (bKill),
    .isLoad  (bIsLoad),
    .exDest  (destBus.bEx),
    .memDest (destBus.bMem)
  );

  // ----------------------------------------------------------
  // S and T bus comparators
  // ----------------------------------------------------------
  specCompare sCompare (
    .phi1      (phi1),
    .rstN      (rstN),
    .stall     (stall),
    .srcSpec   (sSrcSpec),
    .dest      (destBus.cmp),
    .bypassSel (sBypassSel)
  );

  specCompare tCompare (
    .phi1      (phi1),
    .rstN      (rstN),
    .stall     (stall),
    .srcSpec   (tSrcSpec),
    .dest      (destBus.cmp),
    .bypassSel (tBypassSel)
  );

  // Enables and load tracking
  bypassCtrl bypassCtrl (
    .phi1        (phi1),
    .rstN        (rstN),
    .stall       (stall),
    .except      (except),
    .dest        (destBus.ctrl),
    .sBypassSel  (sBypassSel),
    .tBypassSel  (tBypassSel),
    .aExEn       (aExEn),
    .aMemEn      (aMemEn),
    .bExEn       (bExEn),
    .bMemEn      (bMemEn),
    .bWasLoad    (bWasLoad),
    .sBypassLoad (sBypassLoad),
    .tBypassLoad (tBypassLoad),
    .loadWriteEn (loadWriteEn)
  );

endmodule

`default_nettype wire

/* tb/tbClock.sv */
/*
 * Testbench clock and reset generator
 * Free-running clock and an active-low reset held for a few cycles
 */
`timescale 1ns/10ps
`default_nettype none

module tbClock #(
  parameter int periodNs    = 4,
  parameter int resetCycles = 4
) (
  output logic clk,
  output logic rstN
);

  // Free-running clock, first rising edge at half a period
  initial begin
    clk = 1'b0;
    forever #(periodNs / 2) clk = ~clk;
  end

  // Reset released on a rising edge, seen by the DUT one edge later
  initial begin
    rstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    rstN <= 1'b1;
  end

endmodule

`default_nettype wire

/* tb/bypassSpec_assert.sv */
/*
 * Concurrent checks on the bypass selects and datapath enables
 * Bound into the bypassSpec top level
 */
`timescale 1ns/10ps
`default_nettype none

module selEnableProps import bypassPkg::*; (
  input logic      phi1,
  input logic      rstN,
  input logic      stall,
  input bypassSelT sBypassSel,
  input bypassSelT tBypassSel,
  input logic      aExEn,
  input logic      aMemEn,
  input logic      bExEn,
  input logic      bMemEn
);

  // Read by the testbench at the end of the run
  int failCount = 0;

  // ----------------------------------------------------------
  // Select encoding
  // ----------------------------------------------------------
  sOneHot: assert property (@(posedge phi1) disable iff (!rstN) $onehot(sBypassSel))
    else begin
      $error("S bypass select is not one-hot");
      failCount++;
    end

  tOneHot: assert property (@(posedge phi1) disable iff (!rstN) $onehot(tBypassSel))
    else begin
      $error("T bypass select is not one-hot");
      failCount++;
    end

  // ----------------------------------------------------------
  // Stall behaviour
  // ----------------------------------------------------------
  // No stage may advance its datapath while frozen
  noEnableInStall: assert property (@(posedge phi1) disable iff (!rstN)
      stall |-> !(aExEn || aMemEn || bExEn || bMemEn))
    else begin
      $error("Stage enable high while stall is high");
      failCount++;
    end

  // Select registers hold across a stalled edge
  selHoldInStall: assert property (@(posedge phi1) disable iff (!rstN)
      stall |=> ($stable(sBypassSel) && $stable(tBypassSel)))
    else begin
      $error("Bypass select changed across a stalled edge");
      failCount++;
    end

endmodule

bind bypassSpec selEnableProps propChecks (
  .phi1       (phi1),
  .rstN       (rstN),
  .stall      (stall),
  .sBypassSel (sBypassSel),
  .tBypassSel (tBypassSel),
  .aExEn      (aExEn),
  .aMemEn     (aMemEn),
  .bExEn      (bExEn),
  .bMemEn     (bMemEn)
);

`default_nettype wire

/* tb/bypassSpecTb.sv */
/*
 * Testbench for the register-specifier bypass logic
 * Seeded random issue, stall and exception stimulus against a cycle model
 * Compare tasks per result kind, cycle-limit timeout, closing result line
 */
`timescale 1ns/10ps
`default_nettype none

module bypassSpecTb import bypassPkg::*; ();

  localparam int numCycles  = 2000;
  localparam int cycleLimit = numCycles + 20;

  logic      phi1;
  logic      rstN;
  logic      stall;
  logic      except;
  destSelE   aDestSel;
  destSelE   bDestSel;
  specT      aRtSpec;
  specT      aRdSpec;
  specT      bRtSpec;
  specT      bRdSpec;
  specT      sSrcSpec;
  specT      tSrcSpec;
  logic      aKill;
  logic      bKill;
  logic      bIsLoad;
  bypassSelT sBypassSel;
  bypassSelT tBypassSel;
  logic      sBypassLoad;
  logic      tBypassLoad;
  logic      bWasLoad;
  logic      aExEn;
  logic      aMemEn;
  logic      bExEn;
  logic      bMemEn;
  logic      loadWriteEn;

  // Model state mirroring the DUT registers
  destT      mAEx;
  destT      mAMem;
  destT      mBEx;
  destT      mBMem;
  destT      mWb;
  bypassSelT mSSel;
  bypassSelT mTSel;
  logic      mStallDly;

  integer seed = 19;
  int     selErrors = 0;
  int     bitErrors = 0;
  int     cycleCount = 0;

  tbClock clockGen (
    .clk  (phi1),
    .rstN (rstN)
  );

  bypassSpec bypassSpec_inst (.*);

  // ----------------------------------------------------------
  // Random helpers
  // ----------------------------------------------------------
  function int randBelow(int n);
    return $unsigned($random(seed)) % n;
  endfunction

  // Small range plus r31 so that matches are frequent
  function specT randSpec();
    int r;
    r = randBelow(5);
    if (r == 4) begin
      return LINK_REG;
    end
    return specT'(r);
  endfunction

  task automatic initInputs();
    stall    = 1'b0;
    except   = 1'b0;
    aDestSel = destNone;
    bDestSel = destNone;
    aRtSpec  = '0;
    aRdSpec  = '0;
    bRtSpec  = '0;
    bRdSpec  = '0;
    sSrcSpec = '0;
    tSrcSpec = '0;
    aKill    = 1'b0;
    bKill    = 1'b0;
    bIsLoad  = 1'b0;
  endtask

  task automatic driveRandom();
    aDestSel <= destSelE'(randBelow(4));
    bDestSel <= destSelE'(randBelow(4));
    aRtSpec  <= randSpec();
    aRdSpec  <= randSpec();
    bRtSpec  <= randSpec();
    bRdSpec  <= randSpec();
    sSrcSpec <= randSpec();
    tSrcSpec <= randSpec();
    aKill    <= (randBelow(8) == 0);
    bKill    <= (randBelow(8) == 0);
    bIsLoad  <= (randBelow(2) == 1);
    stall    <= (randBelow(100) < 15);
    except   <= (randBelow(100) < 3);
  endtask

  // ----------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------
  task automatic resetModel();
    mAEx      = '0;
    mAMem     = '0;
    mBEx      = '0;
    mBMem     = '0;
    mWb       = '0;
    mSSel     = '0;
    mSSel[srcNone] = 1'b1;
    mTSel     = mSSel;
    mStallDly = 1'b0;
  endtask

  // Issued destination is valid only for a real nonzero target
  function automatic destT issueEntry(destSelE sel, specT rt, specT rd, logic linkOk,
                                      logic killed, logic load, logic flush);
    destT e;
    logic target;
    e.spec   = '0;
    e.isLoad = load;
    target   = 1'b1;
    if (sel == destRd) begin
      e.spec = rd;
    end else if (sel == destRt) begin
      e.spec = rt;
    end else if (sel == destR31 && linkOk) begin
      e.spec = LINK_REG;
    end else begin
      target = 1'b0;
    end
    e.valid = target && !killed && (e.spec != 0) && !flush;
    return e;
  endfunction

  // Youngest match wins with B before A in the same stage
  function automatic bypassSelT pickSource(specT src);
    bypassSelT sel;
    sel = '0;
    if (mBEx.valid && mBEx.spec == src) begin
      sel[srcBEx] = 1'b1;
    end else if (mAEx.valid && mAEx.spec == src) begin
      sel[srcAEx] = 1'b1;
    end else if (mBMem.valid && mBMem.spec == src) begin
      sel[srcBMem] = 1'b1;
    end else if (mAMem.valid && mAMem.spec == src) begin
      sel[srcAMem] = 1'b1;
    end else begin
      sel[srcNone] = 1'b1;
    end
    return sel;
  endfunction

  // One rising edge with the inputs the DUT sampled
  task automatic updateModel();
    if (!stall) begin
      mSSel = pickSource(sSrcSpec);
      mTSel = pickSource(tSrcSpec);
      mWb   = mBMem;
      mWb.valid = mBMem.valid && !except;
      mAMem = mAEx;
      mAMem.valid = mAEx.valid && !except;
      mBMem = mBEx;
      mBMem.valid = mBEx.valid && !except;
      mAEx = issueEntry(aDestSel, aRtSpec, aRdSpec, 1'b1, aKill, 1'b0, except);
      mBEx = issueEntry(bDestSel, bRtSpec, bRdSpec, 1'b0, bKill, bIsLoad, except);
    end else if (except) begin
      mAEx.valid  = 1'b0;
      mAMem.valid = 1'b0;
      mBEx.valid  = 1'b0;
      mBMem.valid = 1'b0;
      mWb.valid   = 1'b0;
    end
    mStallDly = stall;
  endtask

  // ----------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------
  task automatic compareSel(string name, bypassSelT got, bypassSelT exp);
    if (got !== exp) begin
      $display("error %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
      selErrors++;
    end
  endtask

  task automatic compareBit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("error %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
      bitErrors++;
    end
  endtask

  task automatic checkOutputs();
    logic expWasLoad;
    expWasLoad = mWb.valid && mWb.isLoad;
    compareSel("sBypassSel", sBypassSel, mSSel);
    compareSel("tBypassSel", tBypassSel, mTSel);
    compareBit("aExEn", aExEn, mAEx.valid && !stall);
    compareBit("aMemEn", aMemEn, mAMem.valid && !stall);
    compareBit("bExEn", bExEn, mBEx.valid && !stall);
    compareBit("bMemEn", bMemEn, mBMem.valid && !stall);
    compareBit("bWasLoad", bWasLoad, expWasLoad);
    compareBit("sBypassLoad", sBypassLoad, mSSel[srcBMem] && expWasLoad);
    compareBit("tBypassLoad", tBypassLoad, mTSel[srcBMem] && expWasLoad);
    compareBit("loadWriteEn", loadWriteEn, mBMem.valid && mBMem.isLoad && !mStallDly);
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    int totalErrors;
    initInputs();
    resetModel();
    wait (rstN === 1'b1);
    // Reset state before the first active edge
    @(negedge phi1);
    checkOutputs();
    for (int i = 0; i < numCycles; i++) begin
      @(posedge phi1);
      updateModel();
      driveRandom();
      // Outputs settled mid-cycle
      @(negedge phi1);
      checkOutputs();
    end
    totalErrors = selErrors + bitErrors + bypassSpec_inst.propChecks.failCount;
    $display("Errors: select %0d, flag %0d, assertion %0d", selErrors, bitErrors,
             bypassSpec_inst.propChecks.failCount);
    if (totalErrors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Watchdog on total clock edges
  always @(posedge phi1) begin
    cycleCount++;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout: run did not finish within %0d cycles", cycleLimit);
      $display("Result: FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* files.f */
rtl/bypassPkg.sv
rtl/destIf.sv
rtl/destChain.sv
rtl/specCompare.sv
rtl/bypassCtrl.sv
rtl/bypassSpec.sv
tb/tbClock.sv
tb/bypassSpec_assert.sv
tb/bypassSpecTb.sv

/* Bender.yml */
package:
  name: bypass_spec

sources:
  # Design, in compile order
  - rtl/bypassPkg.sv
  - rtl/destIf.sv
  - rtl/destChain.sv
  - rtl/specCompare.sv
  - rtl/bypassCtrl.sv
  - rtl/bypassSpec.sv

  # Testbench
  - target: simulation
    files:
      - tb/tbClock.sv
      - tb/bypassSpec_assert.sv
      - tb/bypassSpecTb.sv
